// ==== include/hs_config.svh ====
`ifndef HS_CONFIG_SVH
`define HS_CONFIG_SVH

// --------------------
// descriptor table
// --------------------
`define HS_SLOTS 8         // transfer descriptors held by the table
`define HS_LEN_BITS 22     // stored length in 32-bit words

// --------------------
// block sizing
// --------------------
`define HS_BLOCK_MAX 63    // largest block handed to the executor, in words
`define HS_PAGE_BITS 12    // word address bits inside one DRAM page

// --------------------
// peripherals
// --------------------
// one ready flag per direction and section pair
`define HS_READY_BITS 8

`endif

// ==== hw/hs_pkg.sv ====
`include "hs_config.svh"

package hs_pkg;

  // --------------------
  // plain vectors
  // --------------------
  typedef logic [$clog2(`HS_SLOTS)-1:0]  slot_t;
  typedef logic [3:0]                    wb_adr_t;    // slot*2 + word select
  typedef logic [`HS_LEN_BITS-1:0]       len_t;
  typedef logic [31:0]                   addr_t;      // word address
  typedef logic [5:0]                    count_t;
  typedef logic [1:0]                    section_t;
  typedef logic [31-`HS_PAGE_BITS:0]     page_t;
  typedef logic [`HS_PAGE_BITS-1:0]      offset_t;
  typedef logic [`HS_READY_BITS-1:0]     ready_vec_t; // index {rd_op, section}

  // --------------------
  // bundles
  // --------------------
  typedef struct packed {
    logic     active;
    logic     rd_op;
    section_t section;
    len_t     len;
    addr_t    addr;
  } desc_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    wb_adr_t     adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    addr_t    addr;
    count_t   count;
    section_t section;
    logic     rd_op;
  } xfer_cmd_t;

  typedef struct packed {
    page_t    page;
    offset_t  start;
    count_t   count;
    section_t section;
    logic     rd_op;
  } blk_cmd_t;

  typedef enum logic [2:0] {S_POLL, S_CHECK, S_ISSUE, S_WAIT, S_WRITEBACK} sched_state_t;
  typedef enum logic [2:0] {E_IDLE, E_CLIP, E_GRANT, E_ISSUE, E_WORK} exec_state_t;

endpackage

// ==== hw/hs_desc_table.sv ====
`timescale 1ns/1ns
`include "hs_config.svh"

module hs_desc_table
(
  input  logic           CLK,
  input  logic           RST,
  input  hs_pkg::wb_req_t wb_i,
  output hs_pkg::wb_rsp_t wb_o,
  input  hs_pkg::slot_t  rd_slot,
  output hs_pkg::desc_t  rd_desc,
  input  logic           wb_en,
  input  hs_pkg::slot_t  wb_slot,
  input  hs_pkg::desc_t  wb_desc
);

  hs_pkg::desc_t table_q [`HS_SLOTS];
  logic          ack_q;
  logic [31:0]   rdat_q;
  logic          cpu_go;
  hs_pkg::slot_t cpu_slot;
  logic          cpu_word;       // 0 control, 1 address
  hs_pkg::len_t  cpu_len;
  hs_pkg::desc_t cpu_cur;
  logic [31:0]   cpu_rdat;

  // --------------------
  // cpu side decode
  // --------------------
  assign cpu_slot = wb_i.adr[3:1];
  assign cpu_word = wb_i.adr[0];

  // writeback owns the table this cycle, so the cpu access slips by one
  assign cpu_go = wb_i.cyc && wb_i.stb && !ack_q && !wb_en;

  // bytes to words, rounded up
  assign cpu_len = wb_i.dat[23:2] + hs_pkg::len_t'(|wb_i.dat[1:0]);

  assign cpu_cur  = table_q[cpu_slot];
  assign cpu_rdat = cpu_word ? cpu_cur.addr :
                    {cpu_cur.active, cpu_cur.rd_op, cpu_cur.section, 6'd0, cpu_cur.len};

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdat_q;

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      for (int i = 0; i < `HS_SLOTS; i++)
      begin
        table_q[i] <= '0;     // every slot starts inactive
      end
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= cpu_go;        // single cycle, master still holds stb meanwhile
      if (wb_en)
      begin
        table_q[wb_slot] <= wb_desc;
      end
      else if (cpu_go && wb_i.we)
      begin
        if (cpu_word)
        begin
          table_q[cpu_slot].addr <= wb_i.dat;
        end
        else
        begin
          table_q[cpu_slot].active  <= wb_i.dat[31];
          table_q[cpu_slot].rd_op   <= wb_i.dat[30];
          table_q[cpu_slot].section <= wb_i.dat[29:28];
          table_q[cpu_slot].len     <= cpu_len;
        end
      end
    end
  end

  // read ports
  always_ff @(posedge CLK)
  begin
    rd_desc <= table_q[rd_slot];  // scheduler sees it one cycle later
    if (cpu_go)
    begin
      rdat_q <= cpu_rdat;
    end
  end

endmodule

// ==== hw/hs_poll_sched.sv ====
`timescale 1ns/1ns
`include "hs_config.svh"

module hs_poll_sched
(
  input  logic               CLK,
  input  logic               RST,
  input  hs_pkg::ready_vec_t periph_ready,
  output hs_pkg::slot_t      rd_slot,
  input  hs_pkg::desc_t      rd_desc,
  output logic               wb_en,
  output hs_pkg::slot_t      wb_slot,
  output hs_pkg::desc_t      wb_desc,
  output hs_pkg::xfer_cmd_t  cmd,
  output logic               cmd_valid,
  input  logic               cmd_ready,
  input  logic               done,
  input  hs_pkg::count_t     sent,
  output logic               irq,
  output hs_pkg::slot_t      irq_slot
);

  hs_pkg::sched_state_t state;
  hs_pkg::slot_t        ptr;
  hs_pkg::slot_t        next_ptr;
  hs_pkg::ready_vec_t   ready_q;
  hs_pkg::desc_t        cur;        // working copy of the polled slot
  hs_pkg::count_t       blk_words;
  hs_pkg::len_t         new_len;
  logic                 launch;
  logic                 retire;

  assign rd_slot  = ptr;
  assign next_ptr = (ptr == hs_pkg::slot_t'(`HS_SLOTS - 1)) ? '0 : ptr + 1'b1;

  // peripheral picked by direction and section
  assign launch = rd_desc.active && ready_q[{rd_desc.rd_op, rd_desc.section}];
  assign retire = rd_desc.active && (rd_desc.len == '0);  // nothing left to move

  assign blk_words = (rd_desc.len > hs_pkg::len_t'(`HS_BLOCK_MAX)) ?
                     hs_pkg::count_t'(`HS_BLOCK_MAX) : hs_pkg::count_t'(rd_desc.len);

  assign new_len = cur.len - hs_pkg::len_t'(sent);

  // --------------------
  // outputs from state
  // --------------------
  assign cmd_valid = (state == hs_pkg::S_ISSUE);
  assign wb_en     = (state == hs_pkg::S_WRITEBACK);
  assign wb_slot   = ptr;
  assign wb_desc   = cur;
  assign irq       = wb_en && (cur.len == '0);
  assign irq_slot  = ptr;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state   <= hs_pkg::S_POLL;
      ptr     <= '0;
      ready_q <= '0;
    end
    else
    begin
      ready_q <= periph_ready;
      case (state)
        hs_pkg::S_POLL:
          state <= hs_pkg::S_CHECK;       // table read in flight
        hs_pkg::S_CHECK:
        begin
          if (retire)
            state <= hs_pkg::S_WRITEBACK;
          else if (launch)
            state <= hs_pkg::S_ISSUE;
          else
          begin
            ptr   <= next_ptr;
            state <= hs_pkg::S_POLL;
          end
        end
        hs_pkg::S_ISSUE:
          if (cmd_ready)
            state <= hs_pkg::S_WAIT;
        hs_pkg::S_WAIT:
          if (done)
            state <= hs_pkg::S_WRITEBACK;
        default:
        begin
          ptr   <= next_ptr;              // next slot gets the executor
          state <= hs_pkg::S_POLL;
        end
      endcase
    end
  end

  // --------------------
  // command and progress
  // --------------------
  always_ff @(posedge CLK)
  begin
    if (state == hs_pkg::S_CHECK)
    begin
      cur         <= rd_desc;
      cur.active  <= (rd_desc.len != '0);
      cmd.addr    <= rd_desc.addr;
      cmd.count   <= blk_words;
      cmd.section <= rd_desc.section;
      cmd.rd_op   <= rd_desc.rd_op;
    end
    if ((state == hs_pkg::S_WAIT) && done)
    begin
      cur.len    <= new_len;
      cur.addr   <= cur.addr + hs_pkg::addr_t'(sent);
      cur.active <= (new_len != '0);
    end
  end

endmodule

// ==== hw/hs_block_exec.sv ====
`timescale 1ns/1ns
`include "hs_config.svh"

module hs_block_exec
(
  input  logic              CLK,
  input  logic              RST,
  input  hs_pkg::xfer_cmd_t cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output logic              done,
  output hs_pkg::count_t    sent,
  output logic              dram_req,
  input  logic              dram_grant,
  output hs_pkg::blk_cmd_t  blk,
  output logic              blk_issue,
  input  logic              blk_working,
  input  hs_pkg::count_t    blk_count_sent
);

  hs_pkg::exec_state_t    state;
  logic                   work_q;     // blk_working one cycle back
  logic                   blk_end;
  logic [`HS_PAGE_BITS:0] page_room;  // words left before the page end

  assign cmd_ready = (state == hs_pkg::E_IDLE);
  assign dram_req  = (state == hs_pkg::E_GRANT) || (state == hs_pkg::E_ISSUE) ||
                     (state == hs_pkg::E_WORK);

  // working was high and has just dropped
  assign blk_end = (state == hs_pkg::E_WORK) && work_q && !blk_working;

  assign page_room = (`HS_PAGE_BITS + 1)'(1 << `HS_PAGE_BITS) - {1'b0, blk.start};

  // --------------------
  // sequencing
  // --------------------
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= hs_pkg::E_IDLE;
      work_q    <= 1'b0;
      blk_issue <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      work_q    <= blk_working;
      blk_issue <= 1'b0;
      done      <= 1'b0;
      case (state)
        hs_pkg::E_IDLE:
          if (cmd_valid)
            state <= hs_pkg::E_CLIP;
        hs_pkg::E_CLIP:
          state <= hs_pkg::E_GRANT;
        hs_pkg::E_GRANT:
          if (dram_grant)
            state <= hs_pkg::E_ISSUE;
        hs_pkg::E_ISSUE:
        begin
          // mover must be fully idle before the next block goes out
          if (dram_grant && !blk_working && !work_q)
          begin
            blk_issue <= 1'b1;
            state     <= hs_pkg::E_WORK;
          end
        end
        default:
        begin
          if (blk_end)
          begin
            done  <= 1'b1;
            state <= hs_pkg::E_IDLE;
          end
        end
      endcase
    end
  end

  // --------------------
  // block command
  // --------------------
  always_ff @(posedge CLK)
  begin
    if (cmd_ready && cmd_valid)
    begin
      blk.page    <= cmd.addr[31:`HS_PAGE_BITS];
      blk.start   <= cmd.addr[`HS_PAGE_BITS-1:0];
      blk.count   <= cmd.count;
      blk.section <= cmd.section;
      blk.rd_op   <= cmd.rd_op;
    end
    if ((state == hs_pkg::E_CLIP) && ((`HS_PAGE_BITS + 1)'(blk.count) > page_room))
      blk.count <= hs_pkg::count_t'(page_room);   // stop at the page end
    if (blk_end)
      sent <= blk_count_sent;
  end

endmodule

// ==== hw/hyper_sched_top.sv ====
`timescale 1ns/1ns

module hyper_sched_top
(
  input  logic               CLK,
  input  logic               RST,
  input  hs_pkg::wb_req_t    wb_i,
  output hs_pkg::wb_rsp_t    wb_o,
  input  hs_pkg::ready_vec_t periph_ready,
  output logic               dram_req,
  input  logic               dram_grant,
  output hs_pkg::blk_cmd_t   blk,
  output logic               blk_issue,
  input  logic               blk_working,
  input  hs_pkg::count_t     blk_count_sent,
  output logic               irq,
  output hs_pkg::slot_t      irq_slot
);

  // table to scheduler
  hs_pkg::slot_t     rd_slot;
  hs_pkg::desc_t     rd_desc;
  logic              wb_en;
  hs_pkg::slot_t     wb_slot;
  hs_pkg::desc_t     wb_desc;

  // scheduler to executor
  hs_pkg::xfer_cmd_t cmd;
  logic              cmd_valid;
  logic              cmd_ready;
  logic              done;
  hs_pkg::count_t    sent;

  hs_desc_table u_table
  (
    .CLK     (CLK),
    .RST     (RST),
    .wb_i    (wb_i),
    .wb_o    (wb_o),
    .rd_slot (rd_slot),
    .rd_desc (rd_desc),
    .wb_en   (wb_en),
    .wb_slot (wb_slot),
    .wb_desc (wb_desc)
  );

  hs_poll_sched u_sched
  (
    .CLK          (CLK),
    .RST          (RST),
    .periph_ready (periph_ready),
    .rd_slot      (rd_slot),
    .rd_desc      (rd_desc),
    .wb_en        (wb_en),
    .wb_slot      (wb_slot),
    .wb_desc      (wb_desc),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .done         (done),
    .sent         (sent),
    .irq          (irq),
    .irq_slot     (irq_slot)
  );

  hs_block_exec u_exec
  (
    .CLK            (CLK),
    .RST            (RST),
    .cmd            (cmd),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .done           (done),
    .sent           (sent),
    .dram_req       (dram_req),
    .dram_grant     (dram_grant),
    .blk            (blk),
    .blk_issue      (blk_issue),
    .blk_working    (blk_working),
    .blk_count_sent (blk_count_sent)
  );

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ns

module tb_clkgen
(
  output logic CLK,
  output logic RST
);

  // --------------------
  // 8 ns clock
  // --------------------
  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // reset held low for 8 cycles, released on a falling edge
  initial
  begin
    RST = 1'b0;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
  end

endmodule

// ==== sim/hs_tb.sv ====
`timescale 1ns/1ns
`include "hs_config.svh"

module hs_tb;

  localparam int MAX_CYCLES = 20000;  // longest test near 3000 cycles
  localparam int WAIT_LIMIT = 3000;
  localparam int SEED       = 73;

  logic               CLK;
  logic               RST;
  hs_pkg::wb_req_t    wb_i;
  hs_pkg::wb_rsp_t    wb_o;
  hs_pkg::ready_vec_t periph_ready;
  logic               dram_req;
  logic               dram_grant;
  hs_pkg::blk_cmd_t   blk;
  logic               blk_issue;
  logic               blk_working;
  hs_pkg::count_t     blk_count_sent;
  logic               irq;
  hs_pkg::slot_t      irq_slot;

  int               errors = 0;
  int               passed = 0;
  int               failed = 0;
  int               err_mark;
  int               cycles = 0;
  int               ack_count = 0;
  logic [31:0]      lcg_state;
  hs_pkg::count_t   short_sent;       // one-shot override for the mover
  hs_pkg::count_t   mover_words;
  hs_pkg::blk_cmd_t blk_log[$];
  hs_pkg::count_t   sent_log[$];
  hs_pkg::slot_t    irq_log[$];

  tb_clkgen u_clkgen
  (
    .CLK (CLK),
    .RST (RST)
  );

  hyper_sched_top u_dut
  (
    .CLK            (CLK),
    .RST            (RST),
    .wb_i           (wb_i),
    .wb_o           (wb_o),
    .periph_ready   (periph_ready),
    .dram_req       (dram_req),
    .dram_grant     (dram_grant),
    .blk            (blk),
    .blk_issue      (blk_issue),
    .blk_working    (blk_working),
    .blk_count_sent (blk_count_sent),
    .irq            (irq),
    .irq_slot       (irq_slot)
  );

  // --------------------
  // block mover model
  // --------------------
  always
  begin
    @(negedge CLK);
    if (blk_issue === 1'b1)
    begin
      blk_log.push_back(blk);
      mover_words = (short_sent != '0) ? short_sent : blk.count;
      short_sent  = '0;
      sent_log.push_back(mover_words);
      repeat (2) @(negedge CLK);
      blk_working = 1'b1;
      repeat (blk.count) @(negedge CLK);
      blk_working    = 1'b0;
      blk_count_sent = mover_words;
    end
  end

  // ack and irq watch
  always @(negedge CLK)
  begin
    if (wb_o.ack === 1'b1)
      ack_count = ack_count + 1;
    if (irq === 1'b1)
      irq_log.push_back(irq_slot);
  end

  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;  // low bits cycle too fast
  endfunction

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_blk(input string name, input hs_pkg::blk_cmd_t got,
                           input hs_pkg::blk_cmd_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_slot(input string name, input hs_pkg::slot_t got, input hs_pkg::slot_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // --------------------
  // cpu bus
  // --------------------
  task automatic bus_access(input logic we, input hs_pkg::slot_t slot, input logic word,
                            input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n = 0;
    wb_i.cyc = 1'b1;
    wb_i.stb = 1'b1;
    wb_i.we  = we;
    wb_i.adr = {slot, word};
    wb_i.dat = wdat;
    @(negedge CLK);
    while (!wb_o.ack && n < WAIT_LIMIT)
    begin
      @(negedge CLK);
      n++;
    end
    if (!wb_o.ack)
    begin
      errors++;
      $display("bus access to slot %0d word %0d never acknowledged", slot, word);
    end
    rdat = wb_o.dat;
    wb_i = '0;
  endtask

  task automatic program_desc(input hs_pkg::slot_t slot, input logic active, input logic rd_op,
                              input hs_pkg::section_t sec, input int bytes,
                              input hs_pkg::addr_t addr);
    logic [31:0] unused;
    bus_access(1'b1, slot, 1'b1, addr, unused);  // address first, active last
    bus_access(1'b1, slot, 1'b0, {active, rd_op, sec, 4'd0, bytes[23:0]}, unused);
  endtask

  // expected blocks worked out from the length, page and sent counts
  task automatic verify_blocks(input hs_pkg::addr_t addr, input int len,
                               input hs_pkg::section_t sec, input logic rd_op);
    hs_pkg::blk_cmd_t exp;
    hs_pkg::addr_t    a;
    int               rem;
    int               cnt;
    int               room;
    int               idx;
    a   = addr;
    rem = len;
    idx = 0;
    while (rem > 0 && idx < blk_log.size())
    begin
      room = (1 << `HS_PAGE_BITS) - a[`HS_PAGE_BITS-1:0];
      cnt  = (rem < `HS_BLOCK_MAX) ? rem : `HS_BLOCK_MAX;
      if (cnt > room)
        cnt = room;  // page end
      exp.page    = a[31:`HS_PAGE_BITS];
      exp.start   = a[`HS_PAGE_BITS-1:0];
      exp.count   = hs_pkg::count_t'(cnt);
      exp.section = sec;
      exp.rd_op   = rd_op;
      check_blk($sformatf("blk[%0d]", idx), blk_log[idx], exp);
      rem = rem - sent_log[idx];
      a   = a + sent_log[idx];
      idx++;
    end
    if (rem != 0)
    begin
      errors++;
      $display("transfer ended with %0d words still to send", rem);
    end
    check_data("block count", blk_log.size(), idx);
  endtask

  task automatic finish_transfer(input hs_pkg::slot_t slot, input logic rd_op,
                                 input hs_pkg::section_t sec, input hs_pkg::addr_t addr,
                                 input int len);
    logic [31:0] d;
    int          n;
    n = 0;
    while (irq_log.size() == 0 && n < WAIT_LIMIT)
    begin
      @(negedge CLK);
      n++;
    end
    if (irq_log.size() == 0)
    begin
      errors++;
      $display("no interrupt from slot %0d within %0d cycles", slot, WAIT_LIMIT);
    end
    else
      check_slot("irq_slot", irq_log[0], slot);
    repeat (4) @(negedge CLK);
    check_data("irq count", irq_log.size(), 1);
    verify_blocks(addr, len, sec, rd_op);
    bus_access(1'b0, slot, 1'b0, '0, d);
    check_data("ctrl word", d, {1'b0, rd_op, sec, 28'd0});
    bus_access(1'b0, slot, 1'b1, '0, d);
    check_data("addr word", d, addr + len);
  endtask

  task automatic start_test();
    err_mark = errors;
    blk_log.delete();
    sent_log.delete();
    irq_log.delete();
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark)
      passed++;
    else
      failed++;
    $display("%s: %s", name, (errors == err_mark) ? "pass" : "fail");
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_register_access();
    hs_pkg::slot_t    slot;
    hs_pkg::section_t sec;
    hs_pkg::addr_t    addr;
    logic             rd;
    logic [31:0]      d;
    int               acks;
    start_test();
    slot = hs_pkg::slot_t'(lcg_next());
    sec  = hs_pkg::section_t'(lcg_next());
    rd   = lcg_next() & 1;
    addr = lcg_next();
    acks = ack_count;
    check_data("ack", wb_o.ack, 0);      // reset values
    check_data("dram_req", dram_req, 0);
    check_data("irq", irq, 0);
    program_desc(slot, 1'b0, rd, sec, 101, addr);
    bus_access(1'b0, slot, 1'b0, '0, d);
    check_data("ctrl word", d, {1'b0, rd, sec, 6'd0, 22'd26});
    bus_access(1'b0, slot, 1'b1, '0, d);
    check_data("addr word", d, addr);
    repeat (2) @(negedge CLK);
    check_data("ack count", ack_count - acks, 4);
    end_test("register access");
  endtask

  task automatic test_in_page();
    hs_pkg::slot_t    slot;
    hs_pkg::section_t sec;
    hs_pkg::addr_t    addr;
    logic             rd;
    start_test();
    slot = hs_pkg::slot_t'(lcg_next());
    sec  = hs_pkg::section_t'(lcg_next());
    rd   = lcg_next() & 1;
    addr = {lcg_next() & 32'hfffff, 12'd0} + (lcg_next() % (4096 - 130));
    program_desc(slot, 1'b1, rd, sec, 520, addr);
    finish_transfer(slot, rd, sec, addr, 130);  // 63, 63, 4
    end_test("transfer in page");
  endtask

  task automatic test_page_split();
    hs_pkg::slot_t slot;
    hs_pkg::addr_t addr;
    start_test();
    slot = hs_pkg::slot_t'(lcg_next());
    addr = {lcg_next() & 32'hfffff, 12'd4090};
    program_desc(slot, 1'b1, 1'b1, 2'd1, 80, addr);
    finish_transfer(slot, 1'b1, 2'd1, addr, 20);  // 6 then 14
    end_test("page split");
  endtask

  task automatic test_ready_gating();
    hs_pkg::slot_t    slot;
    hs_pkg::section_t sec;
    hs_pkg::addr_t    addr;
    int               words;
    start_test();
    slot  = hs_pkg::slot_t'(lcg_next());
    sec   = hs_pkg::section_t'(lcg_next());
    words = 1 + lcg_next() % 40;
    addr  = lcg_next() & 32'hffff_f000;
    periph_ready = ~(8'd1 << {1'b1, sec});
    // odd byte counts round up to the same word count
    program_desc(slot, 1'b1, 1'b1, sec, words * 4 - lcg_next() % 4, addr);
    repeat (200) @(negedge CLK);
    if (blk_log.size() != 0)
    begin
      errors++;
      $display("block issued while the peripheral was not ready");
    end
    periph_ready = '1;
    finish_transfer(slot, 1'b1, sec, addr, words);
    end_test("ready gating");
  endtask

  task automatic test_short_grant();
    hs_pkg::slot_t    slot;
    hs_pkg::section_t sec;
    hs_pkg::addr_t    addr;
    int               words;
    int               n;
    logic             bad;
    start_test();
    slot  = hs_pkg::slot_t'(lcg_next());
    sec   = hs_pkg::section_t'(lcg_next());
    words = 64 + lcg_next() % 100;
    addr  = {lcg_next() & 32'hfffff, 12'd0} + (lcg_next() % 1000);
    dram_grant = 1'b0;
    short_sent = 6'd10;
    program_desc(slot, 1'b1, 1'b0, sec, words * 4, addr);
    n = 0;
    while (!dram_req && n < WAIT_LIMIT)
    begin
      @(negedge CLK);
      n++;
    end
    bad = !dram_req;
    repeat (50)
    begin
      @(negedge CLK);
      if (!dram_req || blk_log.size() != 0)
        bad = 1'b1;
    end
    if (bad)
    begin
      errors++;
      $display("dram_req not held or block issued without a grant");
    end
    dram_grant = 1'b1;
    finish_transfer(slot, 1'b0, sec, addr, words);
    end_test("short block and grant");
  endtask

  initial
  begin
    wb_i           = '0;
    periph_ready   = '1;
    dram_grant     = 1'b1;
    blk_working    = 1'b0;
    blk_count_sent = '0;
    short_sent     = '0;
    lcg_state      = SEED;
    wait (RST === 1'b1);
    @(negedge CLK);
    test_register_access();
    test_in_page();
    test_page_split();
    test_ready_gating();
    test_short_grant();
    $display("tests passed %0d failed %0d checks in error %0d", passed, failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
hw/hs_pkg.sv
hw/hs_desc_table.sv
hw/hs_poll_sched.sv
hw/hs_block_exec.sv
hw/hyper_sched_top.sv
sim/tb_clkgen.sv
sim/hs_tb.sv
